// File: Bender.yml
package:
  name: tcp_app_notif

sources:
  - include_dirs:
      - .
    files:
      - tcp_notif_pkg.sv
      - tcp_app_notif_cam.sv
      - tcp_app_notif_ctrl.sv
      - tcp_app_notif_datap.sv
      - tcp_app_notif.sv
  - target: test
    include_dirs:
      - .
    files:
      - tcp_app_notif_tb.sv

// File: sim.f
+incdir+.
tcp_notif_pkg.sv
tcp_app_notif_cam.sv
tcp_app_notif_ctrl.sv
tcp_app_notif_datap.sv
tcp_app_notif.sv
tcp_app_notif_tb.sv

// File: tcp_app_notif.sv
`default_nettype none
`timescale 1ns/1ps

`include "tcp_notif_macros.svh"

module tcp_app_notif import tcp_notif_pkg::*; #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
)(
     input  logic                               clk
    ,input  logic                               rst

    ,input  logic                               app_new_flow_val
    ,input  logic   [`FLOWID_W-1:0]             app_new_flow_flowid
    ,input  four_tuple_struct                   app_new_flow_entry
    ,output logic                               app_new_flow_rdy

    ,input  logic                               cfg_wr_val
    ,input  logic   [`NOTIF_CAM_IDX_W-1:0]      cfg_wr_idx
    ,input  logic                               cfg_wr_en_entry
    ,input  logic   [31:0]                      cfg_wr_ip
    ,input  logic   [15:0]                      cfg_wr_port
    ,input  tcp_notif_cam_entry                 cfg_wr_dst

    ,output logic                               notif_noc_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]       notif_noc_data
    ,input  logic                               notif_noc_rdy

    ,output logic   [15:0]                      drop_count
);

    logic   ctrl_datap_store_inputs;
    logic   ctrl_datap_read_cam;
    logic   datap_ctrl_cam_hit;

    tcp_app_notif_ctrl u_ctrl (
         .clk                       (clk)
        ,.rst                       (rst)
        ,.app_new_flow_val          (app_new_flow_val)
        ,.app_new_flow_rdy          (app_new_flow_rdy)
        ,.ctrl_datap_store_inputs   (ctrl_datap_store_inputs)
        ,.ctrl_datap_read_cam       (ctrl_datap_read_cam)
        ,.datap_ctrl_cam_hit        (datap_ctrl_cam_hit)
        ,.notif_noc_val             (notif_noc_val)
        ,.notif_noc_rdy             (notif_noc_rdy)
        ,.drop_count                (drop_count)
    );

    tcp_app_notif_datap #(
         .SRC_X (SRC_X)
        ,.SRC_Y (SRC_Y)
    ) u_datap (
         .clk                       (clk)
        ,.rst                       (rst)
        ,.app_new_flow_flowid       (app_new_flow_flowid)
        ,.app_new_flow_entry        (app_new_flow_entry)
        ,.ctrl_datap_store_inputs   (ctrl_datap_store_inputs)
        ,.ctrl_datap_read_cam       (ctrl_datap_read_cam)
        ,.cfg_wr_val                (cfg_wr_val)
        ,.cfg_wr_idx                (cfg_wr_idx)
        ,.cfg_wr_en_entry           (cfg_wr_en_entry)
        ,.cfg_wr_ip                 (cfg_wr_ip)
        ,.cfg_wr_port               (cfg_wr_port)
        ,.cfg_wr_dst                (cfg_wr_dst)
        ,.datap_ctrl_cam_hit        (datap_ctrl_cam_hit)
        ,.notif_noc_data            (notif_noc_data)
    );

endmodule

`default_nettype wire

// File: tcp_app_notif_cam.sv
`default_nettype none
`timescale 1ns/1ps

`include "tcp_notif_macros.svh"

module tcp_app_notif_cam import tcp_notif_pkg::*; (
     input  logic                               clk
    ,input  logic                               rst

    ,input  logic                               cfg_wr_val
    ,input  logic   [`NOTIF_CAM_IDX_W-1:0]      cfg_wr_idx
    ,input  logic                               cfg_wr_en_entry
    ,input  logic   [31:0]                      cfg_wr_ip
    ,input  logic   [15:0]                      cfg_wr_port
    ,input  tcp_notif_cam_entry                 cfg_wr_dst

    ,input  logic   [31:0]                      dst_addr
    ,input  logic   [15:0]                      dst_port
    ,input  logic                               rd_cam_val

    ,output tcp_notif_cam_entry                 rd_cam_data
    ,output logic                               rd_cam_hit
);

    logic   [`NOTIF_CAM_ENTRIES-1:0]    valid_r;
    logic   [31:0]                      ip_r    [`NOTIF_CAM_ENTRIES];
    logic   [15:0]                      port_r  [`NOTIF_CAM_ENTRIES];
    tcp_notif_cam_entry                 dst_r   [`NOTIF_CAM_ENTRIES];

    logic   [`NOTIF_CAM_ENTRIES-1:0]    match;
    logic                               hit_next;
    logic   [`NOTIF_CAM_IDX_W-1:0]      hit_idx;

    // ########################################
    // Configuration writes
    // ########################################
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
        end
        else if (cfg_wr_val) begin
            valid_r[cfg_wr_idx] <= cfg_wr_en_entry;   // Zero invalidates.
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr_val) begin
            ip_r[cfg_wr_idx]   <= cfg_wr_ip;
            port_r[cfg_wr_idx] <= cfg_wr_port;
            dst_r[cfg_wr_idx]  <= cfg_wr_dst;
        end
    end

    // ########################################
    // Parallel match
    // ########################################
    always_comb begin
        for (int i = 0; i < `NOTIF_CAM_ENTRIES; i++) begin
            match[i] = valid_r[i] && (ip_r[i] == dst_addr) && (port_r[i] == dst_port);
        end
    end

    // Walk down so the lowest match is assigned last.
    always_comb begin
        hit_next = 1'b0;
        hit_idx  = '0;
        for (int i = `NOTIF_CAM_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_next = 1'b1;
                hit_idx  = i[`NOTIF_CAM_IDX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cam_hit <= 1'b0;
        end
        else if (rd_cam_val) begin
            rd_cam_hit <= hit_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_cam_val) begin
            rd_cam_data <= hit_next ? dst_r[hit_idx] : '0;   // Held until next lookup.
        end
    end

    a_cfg_idx_range: assert property (@(posedge clk) disable iff (rst)
        cfg_wr_val |-> (!$isunknown(cfg_wr_idx) &&
                        (int'(cfg_wr_idx) < `NOTIF_CAM_ENTRIES)));

endmodule

`default_nettype wire

// File: tcp_app_notif_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module tcp_app_notif_ctrl (
     input  logic           clk
    ,input  logic           rst

    ,input  logic           app_new_flow_val
    ,output logic           app_new_flow_rdy

    ,output logic           ctrl_datap_store_inputs
    ,output logic           ctrl_datap_read_cam
    ,input  logic           datap_ctrl_cam_hit

    ,output logic           notif_noc_val
    ,input  logic           notif_noc_rdy

    ,output logic   [15:0]  drop_count
);

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_LOOKUP   = 2'd1,
        ST_CHECK    = 2'd2,
        ST_SEND     = 2'd3
    } state_e;

    state_e state_r;
    state_e state_next;
    logic   drop_inc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= ST_IDLE;
        end
        else begin
            state_r <= state_next;
        end
    end

    // ########################################
    // Sequencing
    // ########################################
    always_comb begin
        state_next              = state_r;
        app_new_flow_rdy        = 1'b0;
        ctrl_datap_store_inputs = 1'b0;
        ctrl_datap_read_cam     = 1'b0;
        notif_noc_val           = 1'b0;
        drop_inc                = 1'b0;
        case (state_r)
            ST_IDLE: begin
                app_new_flow_rdy = 1'b1;
                if (app_new_flow_val) begin
                    ctrl_datap_store_inputs = 1'b1;   // Capture on this edge.
                    state_next              = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                ctrl_datap_read_cam = 1'b1;
                state_next          = ST_CHECK;
            end
            ST_CHECK: begin
                // Result registered last cycle, so send or drop right away.
                if (datap_ctrl_cam_hit) begin
                    notif_noc_val = 1'b1;
                    state_next    = notif_noc_rdy ? ST_IDLE : ST_SEND;
                end
                else begin
                    drop_inc   = 1'b1;
                    state_next = ST_IDLE;
                end
            end
            ST_SEND: begin
                notif_noc_val = 1'b1;
                if (notif_noc_rdy) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end
        else if (drop_inc && (drop_count != '1)) begin
            drop_count <= drop_count + 16'd1;   // Saturates.
        end
    end

    a_noc_val_hold: assert property (@(posedge clk) disable iff (rst)
        (notif_noc_val && !notif_noc_rdy) |=> notif_noc_val);

    // Lookup must use the tuple captured on the previous edge.
    a_store_then_read: assert property (@(posedge clk) disable iff (rst)
        ctrl_datap_store_inputs |=> (ctrl_datap_read_cam && !ctrl_datap_store_inputs));

endmodule

`default_nettype wire

// File: tcp_app_notif_datap.sv
`default_nettype none
`timescale 1ns/1ps

`include "tcp_notif_macros.svh"

module tcp_app_notif_datap import tcp_notif_pkg::*; #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
)(
     input  logic                               clk
    ,input  logic                               rst

    ,input  logic   [`FLOWID_W-1:0]             app_new_flow_flowid
    ,input  four_tuple_struct                   app_new_flow_entry

    ,input  logic                               ctrl_datap_store_inputs
    ,input  logic                               ctrl_datap_read_cam

    ,input  logic                               cfg_wr_val
    ,input  logic   [`NOTIF_CAM_IDX_W-1:0]      cfg_wr_idx
    ,input  logic                               cfg_wr_en_entry
    ,input  logic   [31:0]                      cfg_wr_ip
    ,input  logic   [15:0]                      cfg_wr_port
    ,input  tcp_notif_cam_entry                 cfg_wr_dst

    ,output logic                               datap_ctrl_cam_hit
    ,output logic   [`NOC_DATA_WIDTH-1:0]       notif_noc_data
);

    logic   [`FLOWID_W-1:0]     flowid_r;
    four_tuple_struct           tuple_r;
    tcp_notif_cam_entry         cam_dst;
    tcp_noc_hdr_flit            hdr_flit;

    always_ff @(posedge clk) begin
        if (ctrl_datap_store_inputs) begin
            flowid_r <= app_new_flow_flowid;
            tuple_r  <= app_new_flow_entry;
        end
    end

    tcp_app_notif_cam u_cam (
         .clk               (clk)
        ,.rst               (rst)
        ,.cfg_wr_val        (cfg_wr_val)
        ,.cfg_wr_idx        (cfg_wr_idx)
        ,.cfg_wr_en_entry   (cfg_wr_en_entry)
        ,.cfg_wr_ip         (cfg_wr_ip)
        ,.cfg_wr_port       (cfg_wr_port)
        ,.cfg_wr_dst        (cfg_wr_dst)
        ,.dst_addr          (tuple_r.host_ip)     // Local socket side.
        ,.dst_port          (tuple_r.host_port)
        ,.rd_cam_val        (ctrl_datap_read_cam)
        ,.rd_cam_data       (cam_dst)
        ,.rd_cam_hit        (datap_ctrl_cam_hit)
    );

    // ########################################
    // Header flit
    // ########################################
    always_comb begin
        hdr_flit                  = '0;
        hdr_flit.core.dst_x_coord = cam_dst.dst_x;
        hdr_flit.core.dst_y_coord = cam_dst.dst_y;
        hdr_flit.core.dst_fbits   = cam_dst.dst_fbits;
        hdr_flit.core.msg_len     = '0;     // Header only.
        hdr_flit.core.src_x_coord = SRC_X[`XY_WIDTH-1:0];
        hdr_flit.core.src_y_coord = SRC_Y[`XY_WIDTH-1:0];
        hdr_flit.core.src_fbits   = TCP_RX_APP_NOTIF_FBITS;
        hdr_flit.core.msg_type    = TCP_NEW_FLOW_NOTIF;
        hdr_flit.flowid           = flowid_r;
    end

    assign notif_noc_data = hdr_flit;

endmodule

`default_nettype wire

// File: tcp_app_notif_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "tcp_notif_macros.svh"

module tcp_app_notif_tb import tcp_notif_pkg::*; ();

    localparam logic [31:0] IP_A = 32'h0a00_0001;
    localparam logic [31:0] IP_B = 32'h0a00_0002;
    localparam int TIMEOUT = 50;

    typedef struct packed {
        logic [`NOTIF_CAM_IDX_W-1:0]    idx;
        logic                           en;
        logic [31:0]                    ip;
        logic [15:0]                    port;
        tcp_notif_cam_entry             dst;
    } cfg_row_t;

    typedef struct packed {
        logic [3:0]                     cfg_upto;   // Config rows applied before this flow.
        four_tuple_struct               tuple;
        logic [`FLOWID_W-1:0]           flowid;
        logic                           exp_hit;
        logic [3:0]                     stall;      // 4'hf picks a random stall.
        tcp_notif_cam_entry             exp_dst;
    } flow_row_t;

    logic clk;
    logic rst;
    logic app_new_flow_val;
    logic [`FLOWID_W-1:0] app_new_flow_flowid;
    four_tuple_struct app_new_flow_entry;
    logic app_new_flow_rdy;
    logic cfg_wr_val;
    logic [`NOTIF_CAM_IDX_W-1:0] cfg_wr_idx;
    logic cfg_wr_en_entry;
    logic [31:0] cfg_wr_ip;
    logic [15:0] cfg_wr_port;
    tcp_notif_cam_entry cfg_wr_dst;
    logic notif_noc_val;
    logic [`NOC_DATA_WIDTH-1:0] notif_noc_data;
    logic notif_noc_rdy;
    logic [15:0] drop_count;

    cfg_row_t  cfg_tbl[$];
    flow_row_t flow_tbl[$];
    int cfg_ptr = 0;
    int err_count = 0;
    int timeout_count = 0;
    logic [31:0] rng = 32'hf219;

    // Listener table as the notifier should see it.
    logic               m_valid [`NOTIF_CAM_ENTRIES];
    logic [31:0]        m_ip    [`NOTIF_CAM_ENTRIES];
    logic [15:0]        m_port  [`NOTIF_CAM_ENTRIES];
    tcp_notif_cam_entry m_dst   [`NOTIF_CAM_ENTRIES];

    tcp_app_notif #(.SRC_X(2), .SRC_Y(5)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic add_cfg(input int idx, input logic en, input logic [31:0] ip,
                           input logic [15:0] port, input int x, input int y, input int f);
        cfg_row_t r;
        r.idx = idx;
        r.en = en;
        r.ip = ip;
        r.port = port;
        r.dst = '{dst_x: x, dst_y: y, dst_fbits: f};
        cfg_tbl.push_back(r);
    endtask

    task automatic add_flow(input int upto, input logic [31:0] ip, input logic [15:0] port,
                            input int fid, input logic hit, input int stall,
                            input int x, input int y, input int f);
        flow_row_t r;
        r.cfg_upto = upto;
        r.tuple = '{host_ip: ip, dest_ip: 32'hc0a8_0100 + fid,
                    host_port: port, dest_port: 16'd40000 + fid};
        r.flowid = fid;
        r.exp_hit = hit;
        r.stall = stall;
        r.exp_dst = '{dst_x: x, dst_y: y, dst_fbits: f};
        flow_tbl.push_back(r);
    endtask

    // Lowest matching valid index wins.
    task automatic model_lookup(input logic [31:0] ip, input logic [15:0] port,
                                output logic hit, output tcp_notif_cam_entry dst);
        hit = 1'b0;
        dst = '0;
        for (int i = 0; i < `NOTIF_CAM_ENTRIES; i++) begin
            if (!hit && m_valid[i] && m_ip[i] == ip && m_port[i] == port) begin
                hit = 1'b1;
                dst = m_dst[i];
            end
        end
    endtask

    task automatic apply_cfg_until(input int upto);
        cfg_row_t c;
        if (cfg_ptr < upto) begin
            while (cfg_ptr < upto) begin
                c = cfg_tbl[cfg_ptr];
                @(posedge clk);
                cfg_wr_val <= 1'b1;
                cfg_wr_idx <= c.idx;
                cfg_wr_en_entry <= c.en;
                cfg_wr_ip <= c.ip;
                cfg_wr_port <= c.port;
                cfg_wr_dst <= c.dst;
                m_valid[c.idx] = c.en;
                m_ip[c.idx] = c.ip;
                m_port[c.idx] = c.port;
                m_dst[c.idx] = c.dst;
                cfg_ptr++;
            end
            @(posedge clk);
            cfg_wr_val <= 1'b0;
        end
    endtask

    task automatic check_flit(input int n, input tcp_noc_hdr_flit f, input flow_row_t r,
                              input tcp_notif_cam_entry d);
        assert (f.core.dst_x_coord == d.dst_x && f.core.dst_y_coord == d.dst_y &&
                f.core.dst_fbits == d.dst_fbits) else begin
            err_count++;
            $display("ERR %0t: flow %0d dst %0h/%0h/%0h, expected %0h/%0h/%0h", $time, n,
                     f.core.dst_x_coord, f.core.dst_y_coord, f.core.dst_fbits,
                     d.dst_x, d.dst_y, d.dst_fbits);
        end
        assert (f.core.src_x_coord == 2 && f.core.src_y_coord == 5 &&
                f.core.src_fbits == TCP_RX_APP_NOTIF_FBITS) else begin
            err_count++;
            $display("ERR %0t: flow %0d wrong source fields", $time, n);
        end
        assert (f.core.msg_len == 0 && f.core.msg_type == TCP_NEW_FLOW_NOTIF &&
                f.padding == 0) else begin
            err_count++;
            $display("ERR %0t: flow %0d wrong msg_len, type or padding", $time, n);
        end
        assert (f.flowid == r.flowid) else begin
            err_count++;
            $display("ERR %0t: flow %0d flowid %0d, expected %0d", $time, n,
                     f.flowid, r.flowid);
        end
    endtask

    // ########################################
    // One flow, from offer to idle
    // ########################################
    task automatic run_flow(input int n);
        flow_row_t r;
        logic m_hit;
        tcp_notif_cam_entry m_dst_exp;
        tcp_noc_hdr_flit flit;
        tcp_noc_hdr_flit first_flit;
        logic [15:0] drops_before;
        int stall;
        int stall_left;
        int k;
        int hs_k;
        int flits;
        int wait_cnt;
        bit seen_val;
        bit done;
        r = flow_tbl[n];
        apply_cfg_until(r.cfg_upto);
        model_lookup(r.tuple.host_ip, r.tuple.host_port, m_hit, m_dst_exp);
        assert (r.exp_hit == m_hit && (!m_hit || r.exp_dst == m_dst_exp)) else begin
            err_count++;
            $display("ERR %0t: flow %0d table entry disagrees with model", $time, n);
        end
        if (r.stall == 4'hf) begin
            rng = xorshift32(rng);
            stall = rng % 6;
        end
        else begin
            stall = r.stall;
        end
        drops_before = drop_count;
        @(posedge clk);
        app_new_flow_val <= 1'b1;
        app_new_flow_flowid <= r.flowid;
        app_new_flow_entry <= r.tuple;
        notif_noc_rdy <= (stall == 0);
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
        end while (!app_new_flow_rdy && wait_cnt < TIMEOUT);
        app_new_flow_val <= 1'b0;
        if (!app_new_flow_rdy) begin
            timeout_count++;
            $display("Timed out waiting for app_new_flow_rdy to accept flow %0d", n);
            return;
        end
        k = 0;
        hs_k = -1;
        flits = 0;
        seen_val = 0;
        done = 0;
        stall_left = stall;
        while (!done && k < TIMEOUT) begin
            @(posedge clk);
            k++;
            if (notif_noc_val) begin
                flit = notif_noc_data;
                if (!seen_val) begin
                    seen_val = 1;
                    first_flit = flit;
                    assert (m_hit) else begin
                        err_count++;
                        $display("ERR %0t: flow %0d flit sent on a miss", $time, n);
                    end
                    assert (stall != 0 || k == 2) else begin
                        err_count++;
                        $display("ERR %0t: flow %0d val rose after %0d cycles", $time, n, k);
                    end
                end
                assert (flit == first_flit && !app_new_flow_rdy) else begin
                    err_count++;
                    $display("ERR %0t: flow %0d flit changed or rdy high", $time, n);
                end
                if (notif_noc_rdy) begin
                    flits++;
                    hs_k = k;
                    check_flit(n, flit, r, m_dst_exp);
                end
                else begin
                    stall_left = stall_left > 0 ? stall_left - 1 : 0;
                    if (stall_left == 0) notif_noc_rdy <= 1'b1;
                end
            end
            else if (app_new_flow_rdy) begin
                done = 1;
                assert (m_hit ? (flits == 1 && hs_k == k - 1 && drop_count == drops_before)
                              : (k == 3 && drop_count == drops_before + 16'd1)) else begin
                    err_count++;
                    $display("ERR %0t: flow %0d rdy at %0d, flits %0d, drops %0d", $time,
                             n, k, flits, drop_count);
                end
            end
        end
        if (!done) begin
            timeout_count++;
            $display("Timed out waiting for the flit or for idle on flow %0d", n);
        end
    endtask

    initial begin
        rst = 1'b1;
        app_new_flow_val = 1'b0;
        app_new_flow_flowid = '0;
        app_new_flow_entry = '0;
        cfg_wr_val = 1'b0;
        cfg_wr_idx = '0;
        cfg_wr_en_entry = 1'b0;
        cfg_wr_ip = '0;
        cfg_wr_port = '0;
        cfg_wr_dst = '0;
        notif_noc_rdy = 1'b0;
        for (int i = 0; i < `NOTIF_CAM_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_ip[i] = '0;
            m_port[i] = '0;
            m_dst[i] = '0;
        end

        add_cfg(2, 1, IP_A, 80, 1, 1, 1);
        add_cfg(5, 1, IP_A, 443, 3, 0, 2);
        add_cfg(6, 1, IP_A, 80, 4, 4, 5);     // Shadowed by index 2.
        add_cfg(1, 1, IP_B, 22, 7, 2, 1);
        add_cfg(2, 0, IP_A, 80, 0, 0, 0);
        add_cfg(5, 1, IP_A, 443, 6, 3, 9);
        add_cfg(1, 0, IP_B, 22, 0, 0, 0);

        add_flow(0, IP_A, 80, 1, 0, 0, 0, 0, 0);
        add_flow(4, IP_A, 80, 2, 1, 0, 1, 1, 1);
        add_flow(4, IP_A, 443, 3, 1, 15, 3, 0, 2);
        add_flow(4, IP_A, 81, 4, 0, 0, 0, 0, 0);
        add_flow(4, 32'h0a00_0009, 80, 5, 0, 0, 0, 0, 0);
        add_flow(4, IP_B, 22, 6, 1, 0, 7, 2, 1);
        add_flow(5, IP_A, 80, 7, 1, 15, 4, 4, 5);
        add_flow(6, IP_A, 443, 8, 1, 15, 6, 3, 9);
        add_flow(7, IP_B, 22, 9, 0, 15, 0, 0, 0);
        add_flow(7, IP_A, 80, 63, 1, 15, 4, 4, 5);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        assert (app_new_flow_rdy && !notif_noc_val && drop_count == 0) else begin
            err_count++;
            $display("ERR %0t: outputs wrong after reset", $time);
        end

        for (int n = 0; n < flow_tbl.size(); n++) begin
            run_flow(n);
        end

        repeat (3) @(posedge clk);
        $display("Done: %0d value errors, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end
        else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tcp_notif_macros.svh
`ifndef TCP_NOTIF_MACROS_SVH
`define TCP_NOTIF_MACROS_SVH

// ########################################
// NoC flit geometry
// ########################################
`define NOC_DATA_WIDTH      128
`define XY_WIDTH            8
`define NOC_FBITS_WIDTH     4     // Endpoint select within a tile.
`define MSG_LEN_WIDTH       8     // Flits after the header.
`define MSG_TYPE_WIDTH      8

// ########################################
// Flow and listener table sizing
// ########################################
`define FLOWID_W            6
`define NOTIF_CAM_ENTRIES   8
`define NOTIF_CAM_IDX_W     3

`endif

// File: tcp_notif_pkg.sv
`default_nettype none

`include "tcp_notif_macros.svh"

package tcp_notif_pkg;

    // Connection four-tuple as reported by the TCP engine.
    typedef struct packed {
        logic [31:0]    host_ip;
        logic [31:0]    dest_ip;
        logic [15:0]    host_port;
        logic [15:0]    dest_port;
    } four_tuple_struct;

    // Listener destination tile.
    typedef struct packed {
        logic [`XY_WIDTH-1:0]           dst_x;
        logic [`XY_WIDTH-1:0]           dst_y;
        logic [`NOC_FBITS_WIDTH-1:0]    dst_fbits;
    } tcp_notif_cam_entry;

    // ########################################
    // NoC header
    // ########################################
    typedef struct packed {
        logic [`XY_WIDTH-1:0]           dst_x_coord;
        logic [`XY_WIDTH-1:0]           dst_y_coord;
        logic [`NOC_FBITS_WIDTH-1:0]    dst_fbits;
        logic [`MSG_LEN_WIDTH-1:0]      msg_len;
        logic [`XY_WIDTH-1:0]           src_x_coord;
        logic [`XY_WIDTH-1:0]           src_y_coord;
        logic [`NOC_FBITS_WIDTH-1:0]    src_fbits;
        logic [`MSG_TYPE_WIDTH-1:0]     msg_type;
    } tcp_noc_hdr_core;

    localparam int HDR_PAD_W = `NOC_DATA_WIDTH - $bits(tcp_noc_hdr_core) - `FLOWID_W;

    // Core at the top of the flit, flow id right below it.
    typedef struct packed {
        tcp_noc_hdr_core            core;
        logic [`FLOWID_W-1:0]       flowid;
        logic [HDR_PAD_W-1:0]       padding;
    } tcp_noc_hdr_flit;

    // ########################################
    // Message encodings
    // ########################################
    localparam logic [`MSG_TYPE_WIDTH-1:0]  TCP_NEW_FLOW_NOTIF     = 8'h21;
    localparam logic [`NOC_FBITS_WIDTH-1:0] TCP_RX_APP_NOTIF_FBITS = 4'h3;

endpackage

`default_nettype wire
